/* lsu_sys_params.svh */
`ifndef LSU_SYS_PARAMS_SVH
`define LSU_SYS_PARAMS_SVH

// datapath widths
`define LSU_DATA_W 32
`define LSU_ADDR_W 32

// entries in the operation queue, power of two
`define LSU_FIFO_DEPTH 4

// data ram size in words
`define LSU_MEM_WORDS 256

// bus size code, log2 of the access bytes
`define LSU_SIZE_W 3

`endif

/* lsu_op_pkg.sv */
`include "lsu_sys_params.svh"

package lsu_op_pkg;

  typedef enum logic [1:0] {
    LSU_OP_NONE  = 2'd0,
    LSU_OP_LOAD  = 2'd1,
    LSU_OP_STORE = 2'd2
  } lsu_op_e;

  // funct3 encoding of the rv32 load and store instructions
  typedef enum logic [2:0] {
    W_B  = 3'b000,
    W_H  = 3'b001,
    W_W  = 3'b010,
    W_BU = 3'b100,
    W_HU = 3'b101
  } lsu_width_e;

  typedef struct packed {
    lsu_op_e                op;
    lsu_width_e             width;
    logic [`LSU_ADDR_W-1:0] addr;   // effective byte address
    logic [`LSU_DATA_W-1:0] data;   // store data, unused for loads
  } lsu_req_t;

endpackage

/* lsu_bus_pkg.sv */
`include "lsu_sys_params.svh"

package lsu_bus_pkg;

  typedef enum logic [`LSU_SIZE_W-1:0] {
    SZ_1 = `LSU_SIZE_W'd0,
    SZ_2 = `LSU_SIZE_W'd1,
    SZ_4 = `LSU_SIZE_W'd2
  } lsu_size_e;

  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;
    lsu_size_e              size;
  } mem_rd_req_t;

  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] data;   // low bytes carry the store value
    lsu_size_e              size;
  } mem_wr_req_t;

endpackage

/* lsu_issue.sv */
`timescale 1ns/1ps
`include "lsu_sys_params.svh"

module lsu_issue
  import lsu_op_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   issue_valid_i,
  input  lsu_op_e                op_i,
  input  lsu_width_e             width_i,
  input  logic [`LSU_DATA_W-1:0] src1_i,
  input  logic [`LSU_DATA_W-1:0] src2_i,
  input  logic [`LSU_DATA_W-1:0] imm_i,
  input  logic                   full_i,
  output logic                   push_o,
  output lsu_req_t               req_o,
  output logic                   stall_o
);

  always_ff @(posedge clk) begin
    if (reset) begin
      push_o <= 1'b0;
    end else begin
      push_o <= issue_valid_i && (op_i != LSU_OP_NONE);  // no-ops never reach the queue
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid_i) begin
      req_o.op    <= op_i;
      req_o.width <= width_i;
      req_o.addr  <= src1_i + imm_i;  // effective address
      req_o.data  <= src2_i;
    end
  end

  assign stall_o = full_i;

endmodule

/* lsu_op_fifo.sv */
`timescale 1ns/1ps
`include "lsu_sys_params.svh"

module lsu_op_fifo
  import lsu_op_pkg::*;
#(
  parameter int DEPTH = `LSU_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     push_i,
  input  lsu_req_t req_i,
  input  logic     pop_i,
  output lsu_req_t head_o,
  output logic     full_o,
  output logic     empty_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  lsu_req_t           buf_q [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) wr_ptr <= wr_ptr + 1'b1;  // pointers wrap, depth is a power of two
      if (pop_i) rd_ptr <= rd_ptr + 1'b1;
      if (push_i && !pop_i) count <= count + 1'b1;
      else if (pop_i && !push_i) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) buf_q[wr_ptr] <= req_i;
  end

  assign head_o  = buf_q[rd_ptr];
  assign empty_o = (count == '0);
  // a push already on its way counts, so the issue stage stops one entry early
  assign full_o  = (count == CNT_W'(DEPTH)) ||
                   ((count == CNT_W'(DEPTH - 1)) && push_i && !pop_i);

endmodule

/* lsu_unit.sv */
`timescale 1ns/1ps
`include "lsu_sys_params.svh"

module lsu_unit
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  lsu_req_t               head_i,
  input  logic                   empty_i,
  input  logic                   rd_ready_i,
  input  logic                   rd_last_i,
  input  logic                   wr_ready_i,
  input  logic                   wr_last_i,
  input  logic [`LSU_DATA_W-1:0] rd_data_i,
  output logic                   pop_o,
  output logic                   rd_valid_o,
  output mem_rd_req_t            rd_req_o,
  output logic                   wr_valid_o,
  output mem_wr_req_t            wr_req_o,
  output logic                   done_o,
  output logic [`LSU_DATA_W-1:0] result_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE
  } state_e;

  state_e                 state_q;
  state_e                 state_d;
  lsu_req_t               req_q;
  lsu_size_e              size;
  logic                   rd_done;
  logic                   wr_done;
  logic [`LSU_DATA_W-1:0] load_ext;

  assign pop_o   = (state_q == ST_IDLE) && !empty_i;
  assign rd_done = (state_q == ST_READ) && rd_ready_i && rd_last_i;
  assign wr_done = (state_q == ST_WRITE) && wr_ready_i && wr_last_i;
  assign done_o  = rd_done || wr_done;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (pop_o && head_i.op == LSU_OP_LOAD) state_d = ST_READ;
        else if (pop_o && head_i.op == LSU_OP_STORE) state_d = ST_WRITE;
      end
      ST_READ: begin
        if (rd_done) state_d = ST_IDLE;
      end
      ST_WRITE: begin
        if (wr_done) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) state_q <= ST_IDLE;
    else state_q <= state_d;
  end

  always_ff @(posedge clk) begin
    if (pop_o) req_q <= head_i;  // held stable for the whole access
  end

  always_comb begin
    case (req_q.width)
      W_B, W_BU: size = SZ_1;
      W_H, W_HU: size = SZ_2;
      default:   size = SZ_4;
    endcase
  end

  // the ram returns the addressed byte in bit 0
  always_comb begin
    case (req_q.width)
      W_B:     load_ext = {{(`LSU_DATA_W-8){rd_data_i[7]}}, rd_data_i[7:0]};
      W_H:     load_ext = {{(`LSU_DATA_W-16){rd_data_i[15]}}, rd_data_i[15:0]};
      W_BU:    load_ext = {{(`LSU_DATA_W-8){1'b0}}, rd_data_i[7:0]};
      W_HU:    load_ext = {{(`LSU_DATA_W-16){1'b0}}, rd_data_i[15:0]};
      default: load_ext = rd_data_i;
    endcase
  end

  assign rd_valid_o = (state_q == ST_READ);
  assign wr_valid_o = (state_q == ST_WRITE);
  assign rd_req_o   = '{addr: req_q.addr, size: size};
  assign wr_req_o   = '{addr: req_q.addr, data: req_q.data, size: size};
  assign result_o   = rd_done ? load_ext : '0;  // stores complete with zero

endmodule

/* lsu_data_ram.sv */
`timescale 1ns/1ps
`include "lsu_sys_params.svh"

module lsu_data_ram
  import lsu_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   rd_valid_i,
  input  mem_rd_req_t            rd_req_i,
  input  logic                   wr_valid_i,
  input  mem_wr_req_t            wr_req_i,
  output logic                   rd_ready_o,
  output logic                   rd_last_o,
  output logic                   wr_ready_o,
  output logic                   wr_last_o,
  output logic [`LSU_DATA_W-1:0] rd_data_o
);

  localparam int LANES  = `LSU_DATA_W / 8;
  localparam int LANE_W = $clog2(LANES);
  localparam int IDX_W  = $clog2(`LSU_MEM_WORDS);

  logic [`LSU_DATA_W-1:0] mem [`LSU_MEM_WORDS];
  logic [IDX_W-1:0]       rd_idx;
  logic [IDX_W-1:0]       wr_idx;
  logic [LANE_W-1:0]      rd_lane;
  logic [LANE_W-1:0]      wr_lane;
  logic [LANES-1:0]       wr_be;
  logic [`LSU_DATA_W-1:0] wr_data_sh;
  logic [`LSU_DATA_W-1:0] rd_mask;

  initial begin
    for (int i = 0; i < `LSU_MEM_WORDS; i++) mem[i] = '0;
  end

  assign rd_idx     = rd_req_i.addr[IDX_W+LANE_W-1:LANE_W];
  assign wr_idx     = wr_req_i.addr[IDX_W+LANE_W-1:LANE_W];
  assign rd_lane    = rd_req_i.addr[LANE_W-1:0];
  assign wr_lane    = wr_req_i.addr[LANE_W-1:0];
  assign wr_data_sh = wr_req_i.data << {wr_lane, 3'b000};  // move into the addressed lane

  always_comb begin
    case (wr_req_i.size)
      SZ_1:    wr_be = LANES'(1) << wr_lane;
      SZ_2:    wr_be = LANES'(3) << wr_lane;
      default: wr_be = '1;
    endcase
    case (rd_req_i.size)
      SZ_1:    rd_mask = `LSU_DATA_W'(8'hff);
      SZ_2:    rd_mask = `LSU_DATA_W'(16'hffff);
      default: rd_mask = '1;
    endcase
  end

  // one beat per access, answered in the cycle after valid
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ready_o <= 1'b0;
      wr_ready_o <= 1'b0;
    end else begin
      rd_ready_o <= rd_valid_i && !rd_ready_o;
      wr_ready_o <= wr_valid_i && !wr_ready_o;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_valid_i && !wr_ready_o) begin
      for (int i = 0; i < LANES; i++) begin
        if (wr_be[i]) mem[wr_idx][i*8 +: 8] <= wr_data_sh[i*8 +: 8];
      end
    end
    if (rd_valid_i && !rd_ready_o) begin
      rd_data_o <= (mem[rd_idx] >> {rd_lane, 3'b000}) & rd_mask;
    end
  end

  assign rd_last_o = rd_ready_o;  // single beat, so every beat is the last
  assign wr_last_o = wr_ready_o;

endmodule

/* lsu_sys.sv */
`timescale 1ns/1ps
`include "lsu_sys_params.svh"

module lsu_sys
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   issue_valid_i,
  input  lsu_op_e                op_i,
  input  lsu_width_e             width_i,
  input  logic [`LSU_DATA_W-1:0] src1_i,
  input  logic [`LSU_DATA_W-1:0] src2_i,
  input  logic [`LSU_DATA_W-1:0] imm_i,
  output logic                   stall_o,
  output logic                   done_o,
  output logic [`LSU_DATA_W-1:0] result_o
);

  logic                   push;
  logic                   pop;
  logic                   full;
  logic                   empty;
  lsu_req_t               issue_req;
  lsu_req_t               head_req;
  logic                   rd_valid;
  logic                   rd_ready;
  logic                   rd_last;
  logic                   wr_valid;
  logic                   wr_ready;
  logic                   wr_last;
  mem_rd_req_t            rd_req;
  mem_wr_req_t            wr_req;
  logic [`LSU_DATA_W-1:0] rd_data;

  lsu_issue u_issue (
    .clk(clk), .reset(reset), .issue_valid_i(issue_valid_i), .op_i(op_i),
    .width_i(width_i), .src1_i(src1_i), .src2_i(src2_i), .imm_i(imm_i),
    .full_i(full), .push_o(push), .req_o(issue_req), .stall_o(stall_o)
  );

  lsu_op_fifo #(.DEPTH(`LSU_FIFO_DEPTH)) u_op_fifo (
    .clk(clk), .reset(reset), .push_i(push), .req_i(issue_req), .pop_i(pop),
    .head_o(head_req), .full_o(full), .empty_o(empty)
  );

  lsu_unit u_unit (
    .clk(clk), .reset(reset), .head_i(head_req), .empty_i(empty),
    .rd_ready_i(rd_ready), .rd_last_i(rd_last), .wr_ready_i(wr_ready),
    .wr_last_i(wr_last), .rd_data_i(rd_data), .pop_o(pop), .rd_valid_o(rd_valid),
    .rd_req_o(rd_req), .wr_valid_o(wr_valid), .wr_req_o(wr_req),
    .done_o(done_o), .result_o(result_o)
  );

  lsu_data_ram u_data_ram (
    .clk(clk), .reset(reset), .rd_valid_i(rd_valid), .rd_req_i(rd_req),
    .wr_valid_i(wr_valid), .wr_req_i(wr_req), .rd_ready_o(rd_ready),
    .rd_last_o(rd_last), .wr_ready_o(wr_ready), .wr_last_o(wr_last),
    .rd_data_o(rd_data)
  );

endmodule

/* lsu_sys_sva.sv */
`timescale 1ns/1ps

module lsu_sys_sva (
  input logic clk,
  input logic reset,
  input logic issue_valid_i,
  input logic stall_i,
  input logic done_i,
  input logic rd_valid_i,
  input logic rd_ready_i,
  input logic rd_last_i,
  input logic wr_valid_i,
  input logic wr_ready_i,
  input logic wr_last_i
);

  no_issue_when_stalled: assert property (@(posedge clk) disable iff (reset)
    !(issue_valid_i && stall_i))
    else $error("issue strobe while the queue reports full");

  // the ram answers one cycle after valid and that beat ends the operation
  rd_answer_next_cycle: assert property (@(posedge clk) disable iff (reset)
    $rose(rd_valid_i) |=> rd_ready_i && rd_last_i && done_i)
    else $error("read channel not answered in the cycle after valid");

  wr_answer_next_cycle: assert property (@(posedge clk) disable iff (reset)
    $rose(wr_valid_i) |=> wr_ready_i && wr_last_i && done_i)
    else $error("write channel not answered in the cycle after valid");

  quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !stall_i && !done_i)
    else $error("stall or done high in the first cycle after reset");

endmodule

bind lsu_sys lsu_sys_sva u_sva (
  .clk(clk), .reset(reset), .issue_valid_i(issue_valid_i), .stall_i(stall_o), .done_i(done_o),
  .rd_valid_i(rd_valid), .rd_ready_i(rd_ready), .rd_last_i(rd_last),
  .wr_valid_i(wr_valid), .wr_ready_i(wr_ready), .wr_last_i(wr_last)
);

/* lsu_sys_tb.sv */
`timescale 1ns/1ps
`include "lsu_sys_params.svh"

module lsu_sys_tb
  import lsu_op_pkg::*;
();

  localparam int MEM_BYTES  = `LSU_MEM_WORDS * (`LSU_DATA_W / 8);
  localparam int MEM_AW     = $clog2(MEM_BYTES);
  localparam int WAIT_LIMIT = 400;

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   issue_valid_i;
  lsu_op_e                op_i;
  lsu_width_e             width_i;
  logic [`LSU_DATA_W-1:0] src1_i;
  logic [`LSU_DATA_W-1:0] src2_i;
  logic [`LSU_DATA_W-1:0] imm_i;
  logic                   stall_o;
  logic                   done_o;
  logic [`LSU_DATA_W-1:0] result_o;
  logic [7:0]             ref_mem [MEM_BYTES];
  logic [`LSU_DATA_W-1:0] exp_q [$];
  string                  name_q [$];
  logic [`LSU_DATA_W-1:0] exp_val;
  string                  exp_name;
  bit                     in_burst = 1'b0;
  bit                     stall_seen = 1'b0;

  lsu_sys u_lsu_sys (
    .clk(clk), .reset(reset), .issue_valid_i(issue_valid_i), .op_i(op_i),
    .width_i(width_i), .src1_i(src1_i), .src2_i(src2_i), .imm_i(imm_i),
    .stall_o(stall_o), .done_o(done_o), .result_o(result_o)
  );

  always #2 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  function automatic int access_bytes(input lsu_width_e w);
    case (w)
      W_B, W_BU: return 1;
      W_H, W_HU: return 2;
      default:   return 4;
    endcase
  endfunction

  // little endian byte memory updated in program order
  function automatic logic [`LSU_DATA_W-1:0] model_access(input lsu_op_e op,
      input lsu_width_e w, input logic [`LSU_DATA_W-1:0] addr,
      input logic [`LSU_DATA_W-1:0] data);
    logic [`LSU_DATA_W-1:0] raw;
    logic [MEM_AW-1:0]      base;
    raw  = '0;
    base = addr[MEM_AW-1:0];
    for (int i = 0; i < access_bytes(w); i++) begin
      if (op == LSU_OP_STORE) ref_mem[base + MEM_AW'(i)] = data[i*8 +: 8];
      raw[i*8 +: 8] = ref_mem[base + MEM_AW'(i)];
    end
    if (op == LSU_OP_STORE) return '0;
    case (w)
      W_B:     return {{(`LSU_DATA_W-8){raw[7]}}, raw[7:0]};
      W_H:     return {{(`LSU_DATA_W-16){raw[15]}}, raw[15:0]};
      default: return raw;  // unsigned widths are already zero filled
    endcase
  endfunction

  // every strobe is followed by a quiet cycle, so stall_o has settled when it is sampled
  task automatic issue_op(input string name, input lsu_op_e op, input lsu_width_e w,
      input logic [`LSU_DATA_W-1:0] src1, input logic [`LSU_DATA_W-1:0] imm,
      input logic [`LSU_DATA_W-1:0] src2);
    int waited;
    waited = 0;
    @(negedge clk);
    while (stall_o) begin
      if (waited >= WAIT_LIMIT) abort_run("stall_o stayed high, the queue never drained");
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
    issue_valid_i <= 1'b1;
    op_i          <= op;
    width_i       <= w;
    src1_i        <= src1;
    imm_i         <= imm;
    src2_i        <= src2;
    exp_q.push_back(model_access(op, w, src1 + imm, src2));
    name_q.push_back(name);
    @(posedge clk);
    issue_valid_i <= 1'b0;
  endtask

  task automatic random_burst(input int count);
    lsu_width_e             w;
    logic [`LSU_DATA_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] imm;
    for (int n = 0; n < count; n++) begin
      case ($urandom % 5)
        0:       w = W_B;
        1:       w = W_H;
        2:       w = W_W;
        3:       w = W_BU;
        default: w = W_HU;
      endcase
      addr = ($urandom % `LSU_MEM_WORDS) * 4;
      if (access_bytes(w) == 1) addr = addr + ($urandom % 4);
      else if (access_bytes(w) == 2) addr = addr + ($urandom % 2) * 2;
      imm = ($urandom % 128) - 32'd64;  // small signed offset
      issue_op("random_burst", ($urandom % 2) ? LSU_OP_STORE : LSU_OP_LOAD, w,
               addr - imm, imm, $urandom);
    end
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    @(posedge clk);
    while (exp_q.size() != 0) begin
      if (waited >= WAIT_LIMIT) abort_run("outstanding operations never completed");
      waited++;
      @(posedge clk);
    end
  endtask

  always @(negedge clk) begin
    if (!reset && in_burst && stall_o) stall_seen = 1'b1;
    if (!reset && done_o) begin
      if (exp_q.size() == 0) begin
        abort_run("done_o pulsed with no operation outstanding");
      end else begin
        exp_val  = exp_q.pop_front();
        exp_name = name_q.pop_front();
        assert (result_o === exp_val)
          else abort_run($sformatf("Error: %s expected %08h actual %08h",
                                   exp_name, exp_val, result_o));
      end
    end
  end

  initial begin
    void'($urandom(32'hf036));
    for (int i = 0; i < MEM_BYTES; i++) ref_mem[i] = 8'h00;
    reset         = 1'b1;
    issue_valid_i = 1'b0;
    op_i          = LSU_OP_NONE;
    width_i       = W_W;
    src1_i        = '0;
    src2_i        = '0;
    imm_i         = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    repeat (6) @(posedge clk);  // nothing issued yet
    issue_op("word_store_load", LSU_OP_STORE, W_W, 32'h40, 32'h0, 32'hdeadbeef);
    issue_op("word_store_load", LSU_OP_LOAD, W_W, 32'h40, 32'h0, 32'h0);
    issue_op("byte_lanes", LSU_OP_STORE, W_W, 32'h80, 32'h0, 32'h11223344);
    issue_op("byte_lanes", LSU_OP_STORE, W_W, 32'h84, 32'h0, 32'h55667788);
    issue_op("byte_lanes", LSU_OP_STORE, W_B, 32'h80, 32'h1, 32'h000000aa);
    issue_op("byte_lanes", LSU_OP_STORE, W_H, 32'h84, 32'h2, 32'h0000bbcc);
    issue_op("byte_lanes", LSU_OP_LOAD, W_W, 32'h80, 32'h0, 32'h0);
    issue_op("byte_lanes", LSU_OP_LOAD, W_W, 32'h84, 32'h0, 32'h0);
    issue_op("load_extend", LSU_OP_STORE, W_W, 32'hc0, 32'h0, 32'h7f80_9080);
    issue_op("load_extend", LSU_OP_LOAD, W_B, 32'hc0, 32'h0, 32'h0);
    issue_op("load_extend", LSU_OP_LOAD, W_BU, 32'hc0, 32'h0, 32'h0);
    issue_op("load_extend", LSU_OP_LOAD, W_H, 32'hc0, 32'h0, 32'h0);
    issue_op("load_extend", LSU_OP_LOAD, W_HU, 32'hc0, 32'h0, 32'h0);
    issue_op("load_extend", LSU_OP_LOAD, W_H, 32'hc0, 32'h2, 32'h0);
    issue_op("load_extend", LSU_OP_LOAD, W_W, 32'hc0, 32'h0, 32'h0);
    issue_op("negative_imm", LSU_OP_STORE, W_W, 32'h200, 32'hffff_fff8, 32'hcafef00d);
    issue_op("negative_imm", LSU_OP_LOAD, W_W, 32'h1f0, 32'h8, 32'h0);
    wait_for_drain();
    in_burst = 1'b1;
    random_burst(32);
    wait_for_drain();
    repeat (4) @(posedge clk);  // a trailing done_o would still meet the monitor
    if (stall_seen) begin
      $display("test passed");
      $finish;
    end else begin
      abort_run("stall_o never rose during the random burst");
    end
  end

endmodule

/* lsu_sys.f */
+incdir+.
lsu_op_pkg.sv
lsu_bus_pkg.sv
lsu_issue.sv
lsu_op_fifo.sv
lsu_unit.sv
lsu_data_ram.sv
lsu_sys.sv
lsu_sys_sva.sv
lsu_sys_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module lsu_sys_tb -f lsu_sys.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vlsu_sys_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "test passed" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1
